// ==== middle_end.f ====
middle_end_pkg.sv
data_memory.sv
phys_reg_file.sv
arithmetic_pipeline.sv
memory_pipeline.sv
terminate_pipeline.sv
middle_end.sv
tb_middle_end.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f middle_end.f \
    --top-module tb_middle_end -Mdir obj_dir -o sim_middle_end

status=0
./obj_dir/sim_middle_end > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Errors found" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation passed"

// ==== tb_middle_end.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_middle_end;
    import middle_end_pkg::*;

    typedef logic [instr_w-1:0] word_t;

    // one slot per row, expected fields shared between slots
    typedef struct packed {
        word_t      a_ins;
        word_t      m_ins;
        word_t      t_ins;
        logic [2:0] vmask;
        areg_t      a_arch;
        areg_t      m_arch;
        logic       we0;
        logic       we1;
        preg_t      wr0;
        preg_t      wr1;
        data_t      v0;
        data_t      v1;
        logic [1:0] lat;
        data_t      e_res;
        data_t      e_flags;
        rob_idx_t   e_rob;
        preg_t      e_dest;
        preg_t      e_flag_reg;
        addr_t      e_addr;
        logic       e_taken;
    } row_t;

    logic     clk;
    logic     rst_n;
    word_t    arith_instr;
    word_t    mem_instr;
    word_t    term_instr;
    logic [2:0] valid_mask;
    areg_t    arch_dest_arith;
    areg_t    arch_dest_mem;
    preg_t    cmplt_reg0;
    preg_t    cmplt_reg1;
    data_t    cmplt_val0;
    data_t    cmplt_val1;
    logic     cmplt_we0;
    logic     cmplt_we1;
    rob_idx_t arith_rob;
    preg_t    arith_dest;
    preg_t    arith_flag_reg;
    data_t    arith_result;
    data_t    arith_flags;
    areg_t    arith_arch_dest;
    logic     arith_valid;
    rob_idx_t mem_rob;
    preg_t    mem_dest;
    data_t    mem_data;
    areg_t    mem_arch_dest;
    addr_t    mem_addr;
    logic     mem_valid;
    logic     mem_input_ready;
    addr_t    term_addr;
    logic     term_taken;
    logic     term_valid;

    data_t      model_regs [32];
    data_t      model_mem [256];
    data_t      model_flags;
    row_t       rows [$];
    preg_t      st_base [$];
    logic [3:0] st_imm [$];
    int         seed = 32'h725e;
    int         errors;
    int         cycles;
    int         cycle_limit = 1000;

    middle_end u_dut (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout: the run went past %0d clock cycles", cycle_limit);
            $display("Errors found");
            $finish;
        end
    end

    // ~~~~~~~~~~ compare tasks ~~~~~~~~~~
    task automatic check_data(input string name, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            errors++;
            $display("Fail at time %0t: %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_addr(input string name, input addr_t expected, input addr_t actual);
        if (actual !== expected) begin
            errors++;
            $display("Fail at time %0t: %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_tag(input string name, input preg_t expected, input preg_t actual);
        if (actual !== expected) begin
            errors++;
            $display("Fail at time %0t: %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_rob(input string name, input rob_idx_t expected,
                             input rob_idx_t actual);
        if (actual !== expected) begin
            errors++;
            $display("Fail at time %0t: %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_arch(input string name, input areg_t expected, input areg_t actual);
        if (actual !== expected) begin
            errors++;
            $display("Fail at time %0t: %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            errors++;
            $display("Fail at time %0t: %s expected %b got %b", $time, name, expected, actual);
        end
    endtask

    // ~~~~~~~~~~ reference model ~~~~~~~~~~
    function automatic data_t rnd();
        return data_t'($random(seed));
    endfunction

    function automatic preg_t rnd_reg();
        return preg_t'($random(seed));
    endfunction

    // keeps base and base + 1 below the flag registers
    function automatic preg_t rnd_base();
        return preg_t'(1 + ($unsigned($random(seed)) % 26));
    endfunction

    function automatic data_t read_reg(input preg_t p);
        if (p == '0) begin
            return '0;
        end else begin
            return model_regs[p];
        end
    endfunction

    function automatic word_t reg_word(input opcode_t op, input preg_t dst, input preg_t flg,
                                       input preg_t a, input preg_t b, input rob_idx_t rob);
        renamed_instr_t w;
        w = '0;
        w.r.opcode = op;
        w.r.dest = dst;
        w.r.flag = flg;
        w.r.src_a = a;
        w.r.src_b = b;
        w.r.rob = rob;
        return w;
    endfunction

    function automatic word_t imm_word(input opcode_t op, input preg_t dst, input preg_t a,
                                       input logic [3:0] imm, input preg_t fsrc,
                                       input rob_idx_t rob);
        renamed_instr_t w;
        w = '0;
        w.i.opcode = op;
        w.i.dest = dst;
        w.i.src_a = a;
        w.i.imm = imm;
        w.i.flag_src = fsrc;
        w.i.rob = rob;
        return w;
    endfunction

    // logic ops and mov keep C of the previous ALU result
    task automatic alu_expect(input opcode_t op, input data_t a, input data_t b,
                              output data_t res, output data_t flg);
        logic carry;
        carry = model_flags[flag_c_bit];
        case (op)
            op_add: begin
                res = a + b;
                carry = (int'(a) + int'(b)) > 255;
            end
            op_sub: begin
                res = a - b;
                carry = a < b;
            end
            op_and: res = a & b;
            op_or: res = a | b;
            op_xor: res = a ^ b;
            default: res = a;
        endcase
        flg = '0;
        flg[flag_z_bit] = (res == 8'h00);
        flg[flag_c_bit] = carry;
        model_flags = flg;
    endtask

    // ~~~~~~~~~~ table builders ~~~~~~~~~~
    task automatic add_arith(input opcode_t op, input preg_t a, input preg_t b);
        row_t  rw;
        data_t res;
        data_t flg;
        rw = '0;
        rw.e_dest = rnd_reg();
        rw.e_flag_reg = rnd_reg();
        rw.e_rob = rob_idx_t'(rnd());
        rw.a_arch = areg_t'(rnd());
        rw.a_ins = reg_word(op, rw.e_dest, rw.e_flag_reg, a, b, rw.e_rob);
        rw.vmask = 3'b100;
        rw.lat = 2'd1;
        alu_expect(op, read_reg(a), read_reg(b), res, flg);
        rw.e_res = res;
        rw.e_flags = flg;
        rows.push_back(rw);
    endtask

    task automatic add_write(input preg_t r0, input data_t v0, input preg_t r1, input data_t v1);
        row_t rw;
        rw = '0;
        rw.we0 = 1'b1;
        rw.we1 = 1'b1;
        rw.wr0 = r0;
        rw.wr1 = r1;
        rw.v0 = v0;
        rw.v1 = v1;
        model_regs[r0] = v0;
        // port 1 lands last
        model_regs[r1] = v1;
        rows.push_back(rw);
    endtask

    task automatic add_mem(input opcode_t op, input preg_t base, input logic [3:0] imm,
                           input preg_t dreg);
        row_t       rw;
        logic [7:0] idx;
        rw = '0;
        rw.e_dest = rnd_reg();
        rw.e_rob = rob_idx_t'(rnd());
        rw.m_arch = areg_t'(rnd());
        rw.m_ins = imm_word(op, rw.e_dest, base, imm, dreg, rw.e_rob);
        rw.vmask = 3'b010;
        rw.lat = 2'd2;
        rw.e_addr = addr_t'(read_reg(base)) + addr_t'(imm);
        idx = rw.e_addr[7:0];
        if (op == op_st) begin
            model_mem[idx] = read_reg(dreg);
        end
        rw.e_res = model_mem[idx];
        rows.push_back(rw);
    endtask

    task automatic add_term(input opcode_t op, input preg_t base, input preg_t off,
                            input preg_t fr, input logic [3:0] imm);
        row_t  rw;
        addr_t base_addr;
        data_t fl;
        rw = '0;
        rw.t_ins = imm_word(op, off, base, imm, fr, rob_idx_t'(rnd()));
        rw.vmask = 3'b001;
        base_addr = {read_reg(preg_t'(base + 5'd1)), read_reg(base)};
        fl = read_reg(fr);
        rw.e_taken = (op == op_jmp) || (op == op_jz && fl[flag_z_bit]) ||
                     (op == op_jc && fl[flag_c_bit]);
        if (rw.e_taken) begin
            rw.e_addr = base_addr + addr_t'(read_reg(off)) + addr_t'(imm);
        end else begin
            rw.e_addr = base_addr + 16'd1;
        end
        rows.push_back(rw);
    endtask

    task automatic build_table();
        opcode_t    alu_ops [6] = '{op_add, op_sub, op_and, op_or, op_xor, op_mov};
        opcode_t    br_ops [3] = '{op_jmp, op_jz, op_jc};
        preg_t      b;
        logic [3:0] imm;
        // fresh registers read zero
        for (int k = 0; k < 4; k++) begin
            add_arith(op_mov, rnd_reg(), '0);
        end
        // r0 gets written too
        for (int k = 0; k < 16; k++) begin
            add_write(preg_t'(2 * k), rnd(), preg_t'(2 * k + 1), rnd());
        end
        add_write(5'd5, rnd(), 5'd5, rnd());
        for (int k = 0; k < 8; k++) begin
            add_arith(op_mov, preg_t'(k), '0);
        end
        for (int k = 0; k < 12; k++) begin
            add_arith(alu_ops[k % 6], rnd_reg(), rnd_reg());
        end
        add_arith(op_sub, 5'd9, 5'd9);
        for (int k = 0; k < 4; k++) begin
            b = rnd_reg();
            imm = 4'(rnd());
            st_base.push_back(b);
            st_imm.push_back(imm);
            add_mem(op_st, b, imm, rnd_reg());
        end
        for (int k = 3; k >= 0; k--) begin
            add_mem(op_ld, st_base[k], st_imm[k], '0);
        end
        // flag bytes: none, Z, C, both
        add_write(5'd29, 8'h00, 5'd30, 8'h01);
        add_write(5'd31, 8'h02, 5'd28, 8'h03);
        for (int k = 0; k < 3; k++) begin
            for (int f = 0; f < 3; f++) begin
                add_term(br_ops[k], rnd_base(), rnd_reg(), preg_t'(29 + f), 4'(rnd()));
            end
        end
        add_term(op_jz, rnd_base(), rnd_reg(), 5'd28, 4'(rnd()));
    endtask

    // ~~~~~~~~~~ drivers ~~~~~~~~~~
    task automatic drive_idle();
        arith_instr = '0;
        mem_instr = '0;
        term_instr = '0;
        valid_mask = 3'b000;
        cmplt_we0 = 1'b0;
        cmplt_we1 = 1'b0;
    endtask

    task automatic check_row(input row_t rw);
        if (rw.vmask[2]) begin
            check_bit("arith_valid", 1'b1, arith_valid);
            check_data("arith_result", rw.e_res, arith_result);
            check_data("arith_flags", rw.e_flags, arith_flags);
            check_rob("arith_rob", rw.e_rob, arith_rob);
            check_tag("arith_dest", rw.e_dest, arith_dest);
            check_tag("arith_flag_reg", rw.e_flag_reg, arith_flag_reg);
            check_arch("arith_arch_dest", rw.a_arch, arith_arch_dest);
        end
        if (rw.vmask[1]) begin
            check_bit("mem_valid", 1'b1, mem_valid);
            check_data("mem_data", rw.e_res, mem_data);
            check_addr("mem_addr", rw.e_addr, mem_addr);
            check_rob("mem_rob", rw.e_rob, mem_rob);
            check_tag("mem_dest", rw.e_dest, mem_dest);
            check_arch("mem_arch_dest", rw.m_arch, mem_arch_dest);
        end
        if (rw.vmask[0]) begin
            check_bit("term_valid", 1'b1, term_valid);
            check_bit("term_taken", rw.e_taken, term_taken);
            check_addr("term_addr", rw.e_addr, term_addr);
        end
    endtask

    // called on a falling edge, returns on a falling edge
    task automatic apply_row(input row_t rw);
        arith_instr = rw.a_ins;
        mem_instr = rw.m_ins;
        term_instr = rw.t_ins;
        valid_mask = rw.vmask;
        arch_dest_arith = rw.a_arch;
        arch_dest_mem = rw.m_arch;
        cmplt_we0 = rw.we0;
        cmplt_we1 = rw.we1;
        cmplt_reg0 = rw.wr0;
        cmplt_reg1 = rw.wr1;
        cmplt_val0 = rw.v0;
        cmplt_val1 = rw.v1;
        if (rw.lat == 2'd0) begin
            #4;
            check_row(rw);
            @(negedge clk);
            drive_idle();
        end else begin
            @(negedge clk);
            drive_idle();
            repeat (int'(rw.lat) - 1) @(negedge clk);
            #4;
            check_row(rw);
            @(negedge clk);
        end
    endtask

    task automatic run_back_to_back();
        data_t r1;
        data_t f1;
        data_t r2;
        data_t f2;
        preg_t pa;
        preg_t pb;
        pa = rnd_reg();
        pb = rnd_reg();
        alu_expect(op_add, read_reg(pa), read_reg(pb), r1, f1);
        alu_expect(op_xor, read_reg(pb), read_reg(pa), r2, f2);
        arith_instr = reg_word(op_add, 5'd7, 5'd8, pa, pb, 5'd9);
        arch_dest_arith = 4'd3;
        valid_mask = 3'b100;
        @(negedge clk);
        arith_instr = reg_word(op_xor, 5'd10, 5'd11, pb, pa, 5'd12);
        arch_dest_arith = 4'd4;
        #4;
        check_bit("arith_valid", 1'b1, arith_valid);
        check_data("arith_result", r1, arith_result);
        check_data("arith_flags", f1, arith_flags);
        check_rob("arith_rob", 5'd9, arith_rob);
        @(negedge clk);
        drive_idle();
        #4;
        check_bit("arith_valid", 1'b1, arith_valid);
        check_data("arith_result", r2, arith_result);
        check_data("arith_flags", f2, arith_flags);
        check_rob("arith_rob", 5'd12, arith_rob);
        check_arch("arith_arch_dest", 4'd4, arith_arch_dest);
        @(negedge clk);
    endtask

    // second load waits out the low ready cycle
    task automatic run_hold_valid();
        addr_t a1;
        addr_t a2;
        a1 = addr_t'(read_reg(st_base[0])) + addr_t'(st_imm[0]);
        a2 = addr_t'(read_reg(st_base[1])) + addr_t'(st_imm[1]);
        mem_instr = imm_word(op_ld, 5'd3, st_base[0], st_imm[0], '0, 5'd1);
        valid_mask = 3'b010;
        #4;
        check_bit("mem_input_ready", 1'b1, mem_input_ready);
        @(negedge clk);
        mem_instr = imm_word(op_ld, 5'd4, st_base[1], st_imm[1], '0, 5'd2);
        #4;
        check_bit("mem_input_ready", 1'b0, mem_input_ready);
        @(negedge clk);
        #4;
        check_bit("mem_input_ready", 1'b1, mem_input_ready);
        check_bit("mem_valid", 1'b1, mem_valid);
        check_data("mem_data", model_mem[a1[7:0]], mem_data);
        check_addr("mem_addr", a1, mem_addr);
        @(negedge clk);
        drive_idle();
        #4;
        check_bit("mem_valid", 1'b0, mem_valid);
        check_bit("mem_input_ready", 1'b0, mem_input_ready);
        @(negedge clk);
        #4;
        check_bit("mem_valid", 1'b1, mem_valid);
        check_data("mem_data", model_mem[a2[7:0]], mem_data);
        check_addr("mem_addr", a2, mem_addr);
        check_rob("mem_rob", 5'd2, mem_rob);
        @(negedge clk);
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        arch_dest_arith = '0;
        arch_dest_mem = '0;
        cmplt_reg0 = '0;
        cmplt_reg1 = '0;
        cmplt_val0 = '0;
        cmplt_val1 = '0;
        drive_idle();
        errors = 0;
        cycles = 0;
        model_flags = '0;
        foreach (model_regs[i]) begin
            model_regs[i] = '0;
        end
        foreach (model_mem[i]) begin
            model_mem[i] = '0;
        end
        build_table();
        cycle_limit = rows.size() * 4 + 50;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        #4;
        check_bit("arith_valid", 1'b0, arith_valid);
        check_bit("mem_valid", 1'b0, mem_valid);
        check_bit("mem_input_ready", 1'b1, mem_input_ready);
        @(negedge clk);
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end
        run_back_to_back();
        run_hold_valid();
        $display("%0d rows applied, %0d errors", rows.size(), errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== middle_end.sv ====
`timescale 1ns/1ps
`default_nettype none

module middle_end #(
    parameter int num_pregs = 32,
    parameter int mem_depth = 256
) (
    input  logic clk,
    input  logic rst_n,
    input  logic [middle_end_pkg::instr_w-1:0] arith_instr,
    input  logic [middle_end_pkg::instr_w-1:0] mem_instr,
    input  logic [middle_end_pkg::instr_w-1:0] term_instr,
    input  logic [2:0] valid_mask,
    input  middle_end_pkg::areg_t    arch_dest_arith,
    input  middle_end_pkg::areg_t    arch_dest_mem,
    input  middle_end_pkg::preg_t    cmplt_reg0,
    input  middle_end_pkg::preg_t    cmplt_reg1,
    input  middle_end_pkg::data_t    cmplt_val0,
    input  middle_end_pkg::data_t    cmplt_val1,
    input  logic cmplt_we0,
    input  logic cmplt_we1,
    output middle_end_pkg::rob_idx_t arith_rob,
    output middle_end_pkg::preg_t    arith_dest,
    output middle_end_pkg::preg_t    arith_flag_reg,
    output middle_end_pkg::data_t    arith_result,
    output middle_end_pkg::data_t    arith_flags,
    output middle_end_pkg::areg_t    arith_arch_dest,
    output logic arith_valid,
    output middle_end_pkg::rob_idx_t mem_rob,
    output middle_end_pkg::preg_t    mem_dest,
    output middle_end_pkg::data_t    mem_data,
    output middle_end_pkg::areg_t    mem_arch_dest,
    output middle_end_pkg::addr_t    mem_addr,
    output logic mem_valid,
    output logic mem_input_ready,
    output middle_end_pkg::addr_t    term_addr,
    output logic term_taken,
    output logic term_valid
);
    import middle_end_pkg::*;

    renamed_instr_t ai;
    renamed_instr_t mi;
    renamed_instr_t ti;

    preg_t [rd_ports-1:0] rd_addr;
    data_t [rd_ports-1:0] rd_val;

    assign ai = renamed_instr_t'(arith_instr);
    assign mi = renamed_instr_t'(mem_instr);
    assign ti = renamed_instr_t'(term_instr);

    // ~~~~~~~~~~ read port map ~~~~~~~~~~
    // mem ops carry the store data register in flag_src
    // term has no destination, its dest field names the offset register
    assign rd_addr[0] = ai.r.src_a;
    assign rd_addr[1] = ai.r.src_b;
    assign rd_addr[2] = mi.i.src_a;
    assign rd_addr[3] = mi.i.flag_src;
    assign rd_addr[4] = ti.i.src_a;
    assign rd_addr[5] = ti.i.flag_src;
    assign rd_addr[6] = ti.i.src_a + preg_t'(1);
    assign rd_addr[7] = ti.i.dest;

    phys_reg_file #(
        .num_pregs(num_pregs)
    ) u_prf (
        .clk(clk),
        .rst_n(rst_n),
        .rd_addr(rd_addr),
        .wr_addr0(cmplt_reg0),
        .wr_addr1(cmplt_reg1),
        .wr_val0(cmplt_val0),
        .wr_val1(cmplt_val1),
        .wr_en0(cmplt_we0),
        .wr_en1(cmplt_we1),
        .rd_val(rd_val)
    );

    // logic ops keep the carry of the last ALU result
    arithmetic_pipeline u_alu (
        .clk(clk),
        .rst_n(rst_n),
        .instr_valid(valid_mask[2]),
        .opcode(ai.r.opcode),
        .rob_entry(ai.r.rob),
        .dest_reg(ai.r.dest),
        .flag_reg(ai.r.flag),
        .op_a_val(rd_val[0]),
        .op_b_val(rd_val[1]),
        .flags_in(arith_flags),
        .arch_dest(arch_dest_arith),
        .rob_entry_out(arith_rob),
        .dest_reg_out(arith_dest),
        .flag_reg_out(arith_flag_reg),
        .result_val(arith_result),
        .result_flags(arith_flags),
        .arch_dest_out(arith_arch_dest),
        .output_valid(arith_valid)
    );

    memory_pipeline #(
        .mem_depth(mem_depth)
    ) u_lsu (
        .clk(clk),
        .rst_n(rst_n),
        .input_valid(valid_mask[1]),
        .opcode(mi.i.opcode),
        .rob_entry(mi.i.rob),
        .dest_reg(mi.i.dest),
        .base_val(rd_val[2]),
        .offset_imm(mi.i.imm),
        .store_data(rd_val[3]),
        .arch_dest(arch_dest_mem),
        .input_ready(mem_input_ready),
        .mem_addr(mem_addr),
        .dest_reg_out(mem_dest),
        .data_out(mem_data),
        .arch_dest_out(mem_arch_dest),
        .rob_entry_out(mem_rob),
        .output_valid(mem_valid)
    );

    terminate_pipeline u_bru (
        .instr_valid(valid_mask[0]),
        .opcode(ti.i.opcode),
        .base_hi(rd_val[6]),
        .base_lo(rd_val[4]),
        .flags_val(rd_val[5]),
        .offset_val(rd_val[7]),
        .immediate(ti.i.imm),
        .target_addr(term_addr),
        .taken(term_taken),
        .result_valid(term_valid)
    );

endmodule

`default_nettype wire

// ==== terminate_pipeline.sv ====
`timescale 1ns/1ps
`default_nettype none

module terminate_pipeline (
    input  logic instr_valid,
    input  middle_end_pkg::opcode_t opcode,
    input  middle_end_pkg::data_t   base_hi,
    input  middle_end_pkg::data_t   base_lo,
    input  middle_end_pkg::data_t   flags_val,
    input  middle_end_pkg::data_t   offset_val,
    input  logic [3:0]              immediate,
    output middle_end_pkg::addr_t   target_addr,
    output logic                    taken,
    output logic                    result_valid
);
    import middle_end_pkg::*;

    addr_t base;

    assign base = {base_hi, base_lo};

    always_comb begin
        case (opcode)
            op_jmp:  taken = 1'b1;
            op_jz:   taken = flags_val[flag_z_bit];
            op_jc:   taken = flags_val[flag_c_bit];
            default: taken = 1'b0;
        endcase
    end

    // fall through is base + 1
    always_comb begin
        if (taken) begin
            target_addr = base + addr_t'(offset_val) + addr_t'(immediate);
        end else begin
            target_addr = base + addr_t'(1);
        end
    end

    assign result_valid = instr_valid;

endmodule

`default_nettype wire

// ==== memory_pipeline.sv ====
`timescale 1ns/1ps
`default_nettype none

module memory_pipeline #(
    parameter int mem_depth = 256
) (
    input  logic clk,
    input  logic rst_n,
    input  logic input_valid,
    input  middle_end_pkg::opcode_t  opcode,
    input  middle_end_pkg::rob_idx_t rob_entry,
    input  middle_end_pkg::preg_t    dest_reg,
    input  middle_end_pkg::data_t    base_val,
    input  logic [3:0]               offset_imm,
    input  middle_end_pkg::data_t    store_data,
    input  middle_end_pkg::areg_t    arch_dest,
    output logic input_ready,
    output middle_end_pkg::addr_t    mem_addr,
    output middle_end_pkg::preg_t    dest_reg_out,
    output middle_end_pkg::data_t    data_out,
    output middle_end_pkg::areg_t    arch_dest_out,
    output middle_end_pkg::rob_idx_t rob_entry_out,
    output logic output_valid
);
    import middle_end_pkg::*;

    logic  accept;
    logic  is_store;
    addr_t agu_addr;
    logic  s1_valid;
    logic  s1_store;
    data_t s1_data;
    data_t ram_dout;

    assign accept   = input_valid && input_ready;
    assign is_store = (opcode == op_st);
    assign agu_addr = addr_t'(base_val) + addr_t'(offset_imm);

    // one op every other cycle
    assign input_ready = !s1_valid;

    // ~~~~~~~~~~~~~ stage 1 ~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= accept;
        end
    end

    // tags hold until the next accept, which is after stage 2
    always_ff @(posedge clk) begin
        if (accept) begin
            mem_addr      <= agu_addr;
            s1_store      <= is_store;
            s1_data       <= store_data;
            dest_reg_out  <= dest_reg;
            arch_dest_out <= arch_dest;
            rob_entry_out <= rob_entry;
        end
    end

    data_memory #(
        .mem_depth(mem_depth)
    ) u_dmem (
        .clk(clk),
        .addr(agu_addr),
        .we(accept && is_store),
        .din(store_data),
        .dout(ram_dout)
    );

    // ~~~~~~~~~~~~~ stage 2 ~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            output_valid <= 1'b0;
        end else begin
            output_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            data_out <= s1_store ? s1_data : ram_dout;
        end
    end

    // issuing slot keeps valid up until ready returns
    a_hold_valid: assert property (@(posedge clk) disable iff (!rst_n)
        input_valid && !input_ready |=> input_valid);

endmodule

`default_nettype wire

// ==== arithmetic_pipeline.sv ====
`timescale 1ns/1ps
`default_nettype none

module arithmetic_pipeline (
    input  logic clk,
    input  logic rst_n,
    input  logic instr_valid,
    input  middle_end_pkg::opcode_t  opcode,
    input  middle_end_pkg::rob_idx_t rob_entry,
    input  middle_end_pkg::preg_t    dest_reg,
    input  middle_end_pkg::preg_t    flag_reg,
    input  middle_end_pkg::data_t    op_a_val,
    input  middle_end_pkg::data_t    op_b_val,
    input  middle_end_pkg::data_t    flags_in,
    input  middle_end_pkg::areg_t    arch_dest,
    output middle_end_pkg::rob_idx_t rob_entry_out,
    output middle_end_pkg::preg_t    dest_reg_out,
    output middle_end_pkg::preg_t    flag_reg_out,
    output middle_end_pkg::data_t    result_val,
    output middle_end_pkg::data_t    result_flags,
    output middle_end_pkg::areg_t    arch_dest_out,
    output logic output_valid
);
    import middle_end_pkg::*;

    logic [data_w:0] wide;
    data_t           res;
    logic            carry;

    always_comb begin
        wide  = '0;
        carry = flags_in[flag_c_bit];
        case (opcode)
            op_add: begin
                wide  = {1'b0, op_a_val} + {1'b0, op_b_val};
                carry = wide[data_w];
            end
            // bit 8 of the wide difference is the borrow
            op_sub: begin
                wide  = {1'b0, op_a_val} - {1'b0, op_b_val};
                carry = wide[data_w];
            end
            op_and:  wide[data_w-1:0] = op_a_val & op_b_val;
            op_or:   wide[data_w-1:0] = op_a_val | op_b_val;
            op_xor:  wide[data_w-1:0] = op_a_val ^ op_b_val;
            default: wide[data_w-1:0] = op_a_val;
        endcase
        res = wide[data_w-1:0];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            output_valid <= 1'b0;
            result_flags <= '0;
        end else begin
            output_valid <= instr_valid;
            if (instr_valid) begin
                result_flags             <= '0;
                result_flags[flag_z_bit] <= (res == '0);
                result_flags[flag_c_bit] <= carry;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            result_val    <= res;
            rob_entry_out <= rob_entry;
            dest_reg_out  <= dest_reg;
            flag_reg_out  <= flag_reg;
            arch_dest_out <= arch_dest;
        end
    end

    // the front end steers only ALU ops into this slot
    a_arith_op: assert property (@(posedge clk) disable iff (!rst_n)
        instr_valid |-> opcode inside {op_add, op_sub, op_and, op_or, op_xor, op_mov});

endmodule

`default_nettype wire

// ==== phys_reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module phys_reg_file #(
    parameter int num_pregs = 32
) (
    input  logic clk,
    input  logic rst_n,
    input  middle_end_pkg::preg_t [middle_end_pkg::rd_ports-1:0] rd_addr,
    input  middle_end_pkg::preg_t wr_addr0,
    input  middle_end_pkg::preg_t wr_addr1,
    input  middle_end_pkg::data_t wr_val0,
    input  middle_end_pkg::data_t wr_val1,
    input  logic wr_en0,
    input  logic wr_en1,
    output middle_end_pkg::data_t [middle_end_pkg::rd_ports-1:0] rd_val
);
    import middle_end_pkg::*;

    data_t regs [num_pregs];

    // port 1 is written last so it wins a collision
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < num_pregs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wr_en0) begin
                regs[wr_addr0] <= wr_val0;
            end
            if (wr_en1) begin
                regs[wr_addr1] <= wr_val1;
            end
        end
    end

    // r0 is hardwired zero
    always_comb begin
        for (int p = 0; p < rd_ports; p++) begin
            if (rd_addr[p] == '0 || int'(rd_addr[p]) >= num_pregs) begin
                rd_val[p] = '0;
            end else begin
                rd_val[p] = regs[rd_addr[p]];
            end
        end
    end

    // completion tags come from the renamer's free list
    a_wr0_range: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en0 |-> int'(wr_addr0) < num_pregs);
    a_wr1_range: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en1 |-> int'(wr_addr1) < num_pregs);

endmodule

`default_nettype wire

// ==== data_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_memory #(
    parameter int mem_depth = 256
) (
    input  logic clk,
    input  middle_end_pkg::addr_t addr,
    input  logic we,
    input  middle_end_pkg::data_t din,
    output middle_end_pkg::data_t dout
);
    import middle_end_pkg::*;

    localparam int idx_w = $clog2(mem_depth);

    data_t             mem [mem_depth];
    logic [idx_w-1:0]  idx;

    assign idx = idx_w'(addr % addr_w'(mem_depth));

    initial begin
        for (int i = 0; i < mem_depth; i++) begin
            mem[i] = '0;
        end
    end

    // read returns the old byte on a write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[idx] <= din;
        end
        dout <= mem[idx];
    end

endmodule

`default_nettype wire

// ==== middle_end_pkg.sv ====
`default_nettype none

package middle_end_pkg;

    localparam int data_w = 8;
    localparam int addr_w = 16;
    localparam int rob_w  = 5;
    localparam int preg_w = 5;
    localparam int areg_w = 4;

    typedef logic [data_w-1:0] data_t;
    typedef logic [addr_w-1:0] addr_t;
    typedef logic [rob_w-1:0]  rob_idx_t;
    typedef logic [preg_w-1:0] preg_t;
    typedef logic [areg_w-1:0] areg_t;

    typedef enum logic [3:0] {
        op_add = 4'h0,
        op_sub = 4'h1,
        op_and = 4'h2,
        op_or  = 4'h3,
        op_xor = 4'h4,
        op_mov = 4'h5,
        op_ld  = 4'h6,
        op_st  = 4'h7,
        op_jmp = 4'h8,
        op_jz  = 4'h9,
        op_jc  = 4'ha
    } opcode_t;

    // ~~~~~~~~~~ renamed instruction word ~~~~~~~~~~
    // common header, then a 9-bit tail decoded two ways
    typedef struct packed {
        opcode_t   opcode;
        preg_t     dest;
        preg_t     flag;
        preg_t     src_a;
        rob_idx_t  rob;
        preg_t     src_b;
        logic [3:0] pad;
    } instr_reg_t;

    typedef struct packed {
        opcode_t   opcode;
        preg_t     dest;
        preg_t     flag;
        preg_t     src_a;
        rob_idx_t  rob;
        logic [3:0] imm;
        preg_t     flag_src;
    } instr_imm_t;

    typedef union packed {
        instr_reg_t r;
        instr_imm_t i;
    } renamed_instr_t;

    localparam int instr_w = $bits(renamed_instr_t);

    // register file read ports, see middle_end for the port map
    localparam int rd_ports = 8;

    localparam int flag_z_bit = 0;
    localparam int flag_c_bit = 1;

endpackage

`default_nettype wire
